// File: capture/capture_ctrl.sv
////////////////////
// Capture control for the sample RAMs
// Decimated keep strobe, pre/post trigger counts, write address
// and the rclk/adc_clk pair
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module capture_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  dso_pkg::cap_cfg_t   cap_cfg,
  input  logic                triggered,
  input  logic                restart,      // Clears the counters
  output logic                armed,
  output logic                set_done,     // With the last write
  output logic                en,
  output logic                we,
  output logic [`ADDR_W-1:0]  addr,
  output logic                rclk,
  output logic                adc_clk
);

  logic [15:0]        wait_cnt;             // Cycles since last kept sample
  logic [15:0]        wait_lim;             // 2**decimator - 1
  logic [`ADDR_W:0]   pre_cnt;              // Samples kept before trigger
  logic [`ADDR_W-1:0] post_cnt;             // Samples kept after trigger
  logic [`ADDR_W-1:0] post_nxt;
  logic [`ADDR_W+1:0] fill;                 // Pre count plus trigger position
  logic               run;                  // Capture enabled and not done
  logic               keep;                 // Write this cycle

  assign run      = (cap_cfg.trig_cfg.ttype != 2'b00) && !cap_cfg.trig_cfg.done;
  assign wait_lim = (16'd1 << cap_cfg.decimator) - 16'd1;
  assign keep     = run && (wait_cnt == wait_lim);

  // Armed once the buffer can hold pre plus post samples
  assign fill  = {1'b0, pre_cnt} + {2'b00, cap_cfg.trig_pos};
  assign armed = (fill >= (`ADDR_W+2)'(`RAM_DEPTH));

  assign post_nxt = post_cnt + 1'b1;
  assign set_done = keep && triggered && (post_nxt == cap_cfg.trig_pos);

  assign en      = keep;                    // en and we always together
  assign we      = keep;
  assign adc_clk = ~rclk;                   // Opposite phase to rclk

  ////////////////////
  // Decimation
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      wait_cnt <= '0;
    else if (restart || keep || !run)
      wait_cnt <= '0;                       // Count restarts after each keep
    else
      wait_cnt <= wait_cnt + 16'd1;
  end

  ////////////////////
  // Pre and post trigger counts
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt  <= '0;
      post_cnt <= '0;
    end else if (restart) begin
      pre_cnt  <= '0;
      post_cnt <= '0;
    end else if (keep) begin
      if (triggered)
        post_cnt <= post_nxt;
      else if (!armed)
        pre_cnt <= pre_cnt + 1'b1;          // Stops once armed
    end
  end

  // Write pointer moves after each write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      addr <= '0;
    else if (keep) begin
      if (addr == `ADDR_W'(`RAM_DEPTH - 1))
        addr <= '0;                         // Circular buffer
      else
        addr <= addr + 1'b1;
    end
  end

  // Divide-by-two RAM clock
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      rclk <= 1'b0;
    else
      rclk <= ~rclk;
  end

endmodule

// File: capture/trigger_detect.sv
////////////////////
// Trigger input path
// Source select, sync, edge detect and the triggered latch
////////////////////
`timescale 1ns/1ps

module trigger_detect (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               trig1,
  input  logic               trig2,
  input  dso_pkg::cap_cfg_t  cap_cfg,
  input  logic               armed,         // Enough pre-trigger samples held
  input  logic               restart,
  output logic               triggered
);

  logic trig_src;                           // Selected raw input
  logic sync1, sync2;                       // Two-flop synchroniser
  logic hist;                               // Previous synced value
  logic trig_edge;                          // One-cycle edge in chosen sense
  logic enabled;                            // Capture running
  logic auto_roll;
  logic set_trig;

  assign trig_src  = cap_cfg.trig_cfg.src[0] ? trig2 : trig1;
  assign enabled   = (cap_cfg.trig_cfg.ttype != 2'b00) && !cap_cfg.trig_cfg.done;
  assign auto_roll = (cap_cfg.trig_cfg.ttype == 2'b10);

  // Rising or falling edge of the synced input
  assign trig_edge = cap_cfg.trig_cfg.rise ? (sync2 & ~hist) : (~sync2 & hist);

  assign set_trig  = enabled && armed && (auto_roll || trig_edge);

  ////////////////////
  // Sync and latch
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1     <= 1'b0;
      sync2     <= 1'b0;
      hist      <= 1'b0;
      triggered <= 1'b0;
    end else begin
      sync1 <= trig_src;                    // Async input
      sync2 <= sync1;
      hist  <= sync2;
      if (restart || cap_cfg.trig_cfg.done)
        triggered <= 1'b0;                  // Held only while capturing
      else if (set_trig)
        triggered <= 1'b1;
    end
  end

endmodule

// File: command/cfg_regs.sv
////////////////////
// Capture configuration registers
// Written from the latched command, done flag set by capture
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module cfg_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  dso_pkg::host_cmd_t  cmd_q,        // Source of write data
  input  logic                wr_pos,
  input  logic                wr_dec,
  input  logic                wr_cfg,
  input  logic                set_done,     // Last sample written
  output dso_pkg::cap_cfg_t   cap_cfg,
  output logic                restart       // New capture starts
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_cfg <= '0;                        // trig type 00 so capture stopped
      restart <= 1'b0;
    end else begin
      restart <= 1'b0;
      if (wr_pos)
        cap_cfg.trig_pos <= {cmd_q.byte2[0], cmd_q.byte3};  // 9-bit position
      if (wr_dec)
        cap_cfg.decimator <= cmd_q.byte3[3:0];

      ////////////////////
      // Trigger config
      ////////////////////
      if (set_done) begin
        cap_cfg.trig_cfg.done <= 1'b1;      // Wins over a host write
      end else if (wr_cfg) begin
        cap_cfg.trig_cfg <= {2'b00, cmd_q.byte2[5:0]};
        restart          <= ~cmd_q.byte2[5];  // Clearing d rearms capture
      end
    end
  end

endmodule

// File: command/cmd_decode.sv
////////////////////
// Host command FSM of the scope core
// Latches a command, issues its SPI transfer or register strobe,
// returns the reply byte and releases cmd_rdy
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module cmd_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  dso_pkg::host_cmd_t  cmd,
  input  logic                cmd_rdy,      // Level from UART receiver
  output logic                clr_cmd_rdy,  // Drops cmd_rdy
  output logic [7:0]          resp_data,
  output logic                send_resp,
  input  logic                resp_sent,
  output dso_pkg::spi_req_t   spi_req,      // Held stable by cmd_q
  output logic                wrt_SPI,
  input  logic                SPI_done,
  input  logic [7:0]          EEP_data,
  input  dso_pkg::trig_cfg_t  trig_cfg,     // For TRIG_RD
  output dso_pkg::host_cmd_t  cmd_q,
  output logic                wr_pos,       // Register write strobes
  output logic                wr_dec,
  output logic                wr_cfg
);

  typedef enum logic [1:0] {IDLE, CMD, SPI, RESP} state_t;

  state_t     state, nxt_state;
  logic       spi_ok;                       // Opcode is a legal SPI command
  logic [7:0] gain_code;                    // Pot byte for requested gain

  ////////////////////
  // State and command latch
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      cmd_q <= '0;
    end else begin
      state <= nxt_state;
      if (state == IDLE && cmd_rdy)
        cmd_q <= cmd;                       // Same edge that leaves IDLE
    end
  end

  // Gain setting lives in byte2 bits 4:2
  always_comb begin
    case (cmd_q.byte2[4:2])
      3'd0:    gain_code = `GAIN_CODE_0;
      3'd1:    gain_code = `GAIN_CODE_1;
      3'd2:    gain_code = `GAIN_CODE_2;
      3'd3:    gain_code = `GAIN_CODE_3;
      3'd4:    gain_code = `GAIN_CODE_4;
      3'd5:    gain_code = `GAIN_CODE_5;
      3'd6:    gain_code = `GAIN_CODE_6;
      default: gain_code = `GAIN_CODE_7;
    endcase
  end

  ////////////////////
  // SPI word builder
  ////////////////////
  always_comb begin
    spi_ok  = 1'b0;
    spi_req = '0;
    case (cmd_q.opcode)
      `OP_CFG_GAIN: begin
        spi_ok       = (cmd_q.byte2[1:0] != 2'b11);      // Channel 11 is reserved
        spi_req.ss   = {1'b0, cmd_q.byte2[1:0]} + 3'd1;  // Channel code plus one
        spi_req.data = {`POT_PREFIX, gain_code};
      end
      `OP_TRIG_LVL: begin
        spi_ok       = (cmd_q.byte3 >= `TRIG_LVL_MIN) && (cmd_q.byte3 <= `TRIG_LVL_MAX);
        spi_req.ss   = 3'b000;              // Trigger level pot
        spi_req.data = {`POT_PREFIX, cmd_q.byte3};
      end
      `OP_EEP_WRT: begin
        spi_ok       = 1'b1;
        spi_req.ss   = 3'b100;
        spi_req.data = {`EEP_WR_PREFIX, cmd_q.byte2[5:0], cmd_q.byte3};
      end
      `OP_EEP_RD: begin
        spi_ok       = 1'b1;
        spi_req.ss   = 3'b100;
        spi_req.data = {`EEP_RD_PREFIX, cmd_q.byte2[5:0], 8'h00};  // Data byte unused
      end
      default: begin
        spi_ok = 1'b0;                      // Not an SPI command
      end
    endcase
  end

  ////////////////////
  // Next state and strobes
  ////////////////////
  always_comb begin
    nxt_state   = state;
    wrt_SPI     = 1'b0;
    send_resp   = 1'b0;
    clr_cmd_rdy = 1'b0;
    wr_pos      = 1'b0;
    wr_dec      = 1'b0;
    wr_cfg      = 1'b0;
    resp_data   = `RESP_NAK;                // Unless overridden below
    case (state)
      IDLE: begin
        if (cmd_rdy)
          nxt_state = CMD;
      end
      CMD: begin
        case (cmd_q.opcode)
          `OP_TRIG_POS, `OP_SET_DEC, `OP_TRIG_CFG: begin
            wr_pos      = (cmd_q.opcode == `OP_TRIG_POS);
            wr_dec      = (cmd_q.opcode == `OP_SET_DEC);
            wr_cfg      = (cmd_q.opcode == `OP_TRIG_CFG);
            clr_cmd_rdy = 1'b1;             // No reply for register writes
            nxt_state   = IDLE;
          end
          `OP_CFG_GAIN, `OP_TRIG_LVL, `OP_EEP_WRT, `OP_EEP_RD: begin
            if (spi_ok) begin
              wrt_SPI   = 1'b1;
              nxt_state = SPI;
            end else begin
              send_resp = 1'b1;             // Bad channel or level gets NAK
              nxt_state = RESP;
            end
          end
          `OP_TRIG_RD: begin
            resp_data = trig_cfg;
            send_resp = 1'b1;
            nxt_state = RESP;
          end
          default: begin
            send_resp = 1'b1;               // DUMP_CH lands here too
            nxt_state = RESP;
          end
        endcase
      end
      SPI: begin
        if (SPI_done) begin
          resp_data = (cmd_q.opcode == `OP_EEP_RD) ? EEP_data : `RESP_ACK;
          send_resp = 1'b1;
          nxt_state = RESP;
        end
      end
      default: begin                        // RESP waits for the UART
        if (resp_sent) begin
          clr_cmd_rdy = 1'b1;
          nxt_state   = IDLE;
        end
      end
    endcase
  end

endmodule

// File: common/dso_params.svh
////////////////////
// Sizes, opcodes and SPI codes shared by the scope core and its testbench
// Include in any file that decodes commands or addresses the sample RAM
////////////////////
`ifndef DSO_PARAMS_SVH
`define DSO_PARAMS_SVH

`define RAM_DEPTH     512             // Samples per channel RAM
`define ADDR_W        9               // RAM address bits

// Host command opcodes
`define OP_DUMP_CH    8'h01
`define OP_CFG_GAIN   8'h02
`define OP_TRIG_LVL   8'h03
`define OP_TRIG_POS   8'h04
`define OP_SET_DEC    8'h05
`define OP_TRIG_CFG   8'h06
`define OP_TRIG_RD    8'h07
`define OP_EEP_WRT    8'h08
`define OP_EEP_RD     8'h09

`define RESP_ACK      8'hA5           // Positive reply
`define RESP_NAK      8'hEE           // Bad or unsupported command

`define TRIG_LVL_MIN  8'd46           // Lowest legal trigger level
`define TRIG_LVL_MAX  8'd201          // Highest legal trigger level

`define POT_PREFIX    8'h13           // High byte of every pot write
`define EEP_WR_PREFIX 2'b01
`define EEP_RD_PREFIX 2'b00

// Pot low bytes for the eight gain settings
`define GAIN_CODE_0   8'h02
`define GAIN_CODE_1   8'h05
`define GAIN_CODE_2   8'h09
`define GAIN_CODE_3   8'h14
`define GAIN_CODE_4   8'h28
`define GAIN_CODE_5   8'h46
`define GAIN_CODE_6   8'h6B
`define GAIN_CODE_7   8'hDD

`endif

// File: common/dso_pkg.sv
////////////////////
// Bus types of the scope core
// Command, SPI request and capture configuration structs
////////////////////
`include "dso_params.svh"

package dso_pkg;

  // 24-bit host command as it arrives from the UART
  typedef struct packed {
    logic [7:0] opcode;               // Command byte
    logic [7:0] byte2;                // Channel, gain or EEPROM address
    logic [7:0] byte3;                // Level, position or data
  } host_cmd_t;

  // One SPI transfer
  typedef struct packed {
    logic [2:0]  ss;                  // 000 trig pot, 001..011 gain pots, 100 EEPROM
    logic [15:0] data;                // Word shifted out
  } spi_req_t;

  ////////////////////
  // Trigger config 00dettcc
  ////////////////////
  typedef struct packed {
    logic [1:0] rsvd;                 // Always zero
    logic       done;                 // Capture finished
    logic       rise;                 // 1 rising edge, 0 falling edge
    logic [1:0] ttype;                // 00 stop, 01 normal, 10 auto-roll, 11 normal
    logic [1:0] src;                  // Bit 0 picks trig2
  } trig_cfg_t;

  // Everything the capture path needs
  typedef struct packed {
    logic [`ADDR_W-1:0] trig_pos;     // Samples kept after the trigger
    logic [3:0]         decimator;    // Keep one sample in 2**decimator
    trig_cfg_t          trig_cfg;
  } cap_cfg_t;

endpackage

// File: filelist.f
+incdir+common
common/dso_pkg.sv
command/cmd_decode.sv
command/cfg_regs.sv
capture/trigger_detect.sv
capture/capture_ctrl.sv
src/dig_core.sv
verification/dig_core_sva.sv
verification/dig_core_checker.sv
verification/dig_core_tb.sv

// File: src/dig_core.sv
////////////////////
// Digital core of the three-channel scope
// Joins command decode, config registers, trigger and capture
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module dig_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                trig1,        // Trigger comparator outputs
  input  logic                trig2,
  input  dso_pkg::host_cmd_t  cmd,          // Host command
  input  logic                cmd_rdy,
  output logic                clr_cmd_rdy,
  output logic [7:0]          resp_data,    // Reply byte to host
  output logic                send_resp,
  input  logic                resp_sent,
  output dso_pkg::spi_req_t   spi_req,      // SPI transfer request
  output logic                wrt_SPI,
  input  logic                SPI_done,
  input  logic [7:0]          EEP_data,     // EEPROM read byte
  output logic                en,           // RAM strobes
  output logic                we,
  output logic [`ADDR_W-1:0]  addr,
  output logic                rclk,         // RAM and ADC clocks
  output logic                adc_clk
);

  dso_pkg::host_cmd_t cmd_q;                // Latched command for register writes
  dso_pkg::cap_cfg_t  cap_cfg;              // Live capture configuration
  logic               wr_pos, wr_dec, wr_cfg;
  logic               set_done, restart;
  logic               armed, triggered;

  cmd_decode cmd_decode_inst (
    .clk, .rst_n, .cmd, .cmd_rdy, .clr_cmd_rdy, .resp_data, .send_resp, .resp_sent,
    .spi_req, .wrt_SPI, .SPI_done, .EEP_data,
    .trig_cfg (cap_cfg.trig_cfg),
    .cmd_q, .wr_pos, .wr_dec, .wr_cfg
  );

  cfg_regs cfg_regs_inst (
    .clk, .rst_n, .cmd_q, .wr_pos, .wr_dec, .wr_cfg, .set_done, .cap_cfg, .restart
  );

  trigger_detect trigger_detect_inst (
    .clk, .rst_n, .trig1, .trig2, .cap_cfg, .armed, .restart, .triggered
  );

  capture_ctrl capture_ctrl_inst (
    .clk, .rst_n, .cap_cfg, .triggered, .restart, .armed, .set_done,
    .en, .we, .addr, .rclk, .adc_clk
  );

endmodule

// File: verification/dig_core_checker.sv
////////////////////
// Scoreboard for the scope core testbench
// Compares DUT strobes with expectations from the testbench,
// prints one line per test and the closing counts
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module dig_core_checker (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wrt_SPI, send_resp, clr_cmd_rdy,
  input  dso_pkg::spi_req_t spi_req,
  input  logic [7:0]        resp_data,
  input  logic              en, we, rclk, adc_clk,
  input  logic [`ADDR_W-1:0] addr,
  input  logic              exp_spi,       // Command should issue a transfer
  input  logic              exp_rsp,       // Command should reply
  input  dso_pkg::spi_req_t exp_req,
  input  logic [7:0]        exp_resp,
  input  int                test_num,
  input  logic              test_done,     // One-cycle end of test marker
  input  logic              cap_mode,      // RAM writes allowed
  input  logic              edge_mark,     // Accepted trigger applied
  input  int                trig_pos,
  input  int                cmd_sent,
  input  logic              finish_req,
  output int                errors
);

  int cycle = 0, checks = 0, test_err = 0, tests = 0;
  int spi_cnt = 0, rsp_cnt = 0, clr_total = 0;
  int post_we = 0, last_we_cycle = 0;
  logic last_valid = 1'b0;
  logic [`ADDR_W-1:0] last_addr;
  logic rclk_prev = 1'b0;                          // rclk at previous negedge
  logic ran_prev = 1'b0;                           // Out of reset at previous negedge
  logic summary_done = 1'b0;

  initial errors = 0;

  task automatic report_fail(input string msg);
    $display("FAILED at %0d ns: %s", $time, msg);
    errors++;
    test_err++;
  endtask

  always @(negedge clk) begin
    cycle++;
    if (!rst_n) begin
      checks++;                                    // Reset values
      if (wrt_SPI || send_resp || clr_cmd_rdy || en || we || rclk || !adc_clk)
        report_fail("control output not at reset value");
    end else begin
      // RAM clock pair toggles every cycle in opposite phase
      if (ran_prev && (rclk === rclk_prev || adc_clk !== ~rclk))
        report_fail("rclk and adc_clk not a divide-by-two pair");
      if (wrt_SPI) begin
        spi_cnt++;
        checks++;
        if (!exp_spi)
          report_fail("unexpected wrt_SPI");
        else if (spi_req !== exp_req)
          report_fail($sformatf("spi_req %h expected %h", spi_req, exp_req));
      end
      if (send_resp) begin
        rsp_cnt++;
        checks++;
        if (!exp_rsp)
          report_fail("unexpected send_resp");
        else if (resp_data !== exp_resp)
          report_fail($sformatf("resp_data %h expected %h", resp_data, exp_resp));
      end
      if (en !== we)
        report_fail("en differs from we");
      ////////////////////
      // End of one command
      ////////////////////
      if (clr_cmd_rdy) begin
        clr_total++;
        checks++;
        if (exp_spi && spi_cnt == 0) begin
          $display("Test %0d: an expected SPI write was never issued", test_num);
          errors++;
          test_err++;
        end
        if (exp_rsp && rsp_cnt == 0) begin
          $display("Test %0d: an expected response was never sent", test_num);
          errors++;
          test_err++;
        end
        if (spi_cnt > 1 || rsp_cnt > 1)
          report_fail("more than one strobe for a command");
        spi_cnt = 0;
        rsp_cnt = 0;
      end
      ////////////////////
      // RAM writes
      ////////////////////
      if (we) begin
        checks++;
        if (!cap_mode)
          report_fail("RAM write while capture stopped");
        if (last_valid && (cycle - last_we_cycle) != 4)
          report_fail($sformatf("we spacing %0d cycles", cycle - last_we_cycle));
        if (last_valid && addr !== last_addr + 1'b1)
          report_fail($sformatf("addr %0d after %0d", addr, last_addr));  // Wraps by width
        last_valid    = 1'b1;
        last_we_cycle = cycle;
        last_addr     = addr;
        if (edge_mark)
          post_we++;
      end
    end
    rclk_prev = rclk;
    ran_prev  = rst_n;
    if (test_done) begin
      if (test_num >= 5) begin
        checks++;
        if (post_we != trig_pos)
          report_fail($sformatf("%0d writes after trigger, expected %0d", post_we, trig_pos));
      end
      checks++;
      if (clr_total != cmd_sent)
        report_fail($sformatf("%0d clr_cmd_rdy for %0d commands", clr_total, cmd_sent));
      $display("Test %0d finished: %0d errors", test_num, test_err);
      tests++;
      test_err   = 0;
      post_we    = 0;
      last_valid = 1'b0;
    end
    if (finish_req && !summary_done) begin
      summary_done = 1'b1;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    end
  end

endmodule

// File: verification/dig_core_sva.sv
////////////////////
// Assertions on the scope core strobes and RAM writes
// Bound into the top level so both FSM and capture signals are visible
////////////////////
`timescale 1ns/1ps

module dig_core_sva (
  input logic              clk,
  input logic              rst_n,
  input logic              wrt_SPI,
  input logic              SPI_done,
  input logic              send_resp,
  input logic              clr_cmd_rdy,
  input dso_pkg::spi_req_t spi_req,
  input logic              en,
  input logic              we,
  input logic              done           // Trigger config bit d
);

  logic spi_busy;                         // Between wrt_SPI and SPI_done

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      spi_busy <= 1'b0;
    else if (wrt_SPI)
      spi_busy <= 1'b1;
    else if (SPI_done)
      spi_busy <= 1'b0;
  end

  // Strobes last one cycle
  a_wrt_pulse: assert property (@(posedge clk) disable iff (!rst_n) wrt_SPI |=> !wrt_SPI)
    else $error("wrt_SPI longer than one cycle");
  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n) send_resp |=> !send_resp)
    else $error("send_resp longer than one cycle");
  a_clr_pulse: assert property (@(posedge clk) disable iff (!rst_n) clr_cmd_rdy |=> !clr_cmd_rdy)
    else $error("clr_cmd_rdy longer than one cycle");

  a_en_we: assert property (@(posedge clk) disable iff (!rst_n) en == we)
    else $error("en and we differ");
  a_no_we_done: assert property (@(posedge clk) disable iff (!rst_n) we |-> !done)
    else $error("RAM write after capture done");
  a_spi_stable: assert property (@(posedge clk) disable iff (!rst_n) spi_busy |-> $stable(spi_req))
    else $error("spi_req changed during transfer");

endmodule

bind dig_core dig_core_sva dig_core_sva_inst (
  .clk, .rst_n, .wrt_SPI, .SPI_done, .send_resp, .clr_cmd_rdy, .spi_req, .en, .we,
  .done (cap_cfg.trig_cfg.done)
);

// File: verification/dig_core_tb.sv
////////////////////
// Testbench top for the scope core
// Host and SPI models, command stimulus, capture runs and timeout
////////////////////
`timescale 1ns/1ps
`include "dso_params.svh"

module dig_core_tb;

  typedef struct packed {
    logic              spi;                // Transfer expected
    logic              rsp;                // Reply expected
    dso_pkg::spi_req_t req;
    logic [7:0]        resp;
  } exp_t;

  localparam int TIMEOUT = 20000;          // Five tests plus two 2k-cycle captures
  localparam int POS     = 100;            // Trigger position for captures

  logic clk, rst_n, trig1, trig2, cmd_rdy, resp_sent, SPI_done;
  logic clr_cmd_rdy, send_resp, wrt_SPI, en, we, rclk, adc_clk;
  logic [7:0] resp_data, EEP_data, eep_byte, cfg_model;
  logic [`ADDR_W-1:0] addr;
  dso_pkg::host_cmd_t cmd;
  dso_pkg::spi_req_t  spi_req;
  exp_t exp_q;
  logic test_done, cap_mode, edge_mark, finish_req;
  int   test_num, cmd_sent, errors, cycles;
  logic [31:0] lcg_state;
  int unsigned spi_wait, host_wait;

  dig_core dig_core_inst (.*);

  dig_core_checker dig_core_checker_inst (
    .clk, .rst_n, .wrt_SPI, .send_resp, .clr_cmd_rdy, .spi_req, .resp_data,
    .en, .we, .rclk, .adc_clk, .addr,
    .exp_spi (exp_q.spi), .exp_rsp (exp_q.rsp), .exp_req (exp_q.req), .exp_resp (exp_q.resp),
    .test_num, .test_done, .cap_mode, .edge_mark, .trig_pos (POS), .cmd_sent,
    .finish_req, .errors
  );

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
    return lcg_state;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic exp_t expected_reply(input dso_pkg::host_cmd_t c,
                                          input logic [7:0] cfg, input logic [7:0] eep);
    exp_t e;
    logic [7:0] g;
    e = '0;
    e.rsp  = 1'b1;
    e.resp = `RESP_NAK;
    case (c.byte2[4:2])
      3'd0: g = `GAIN_CODE_0;
      3'd1: g = `GAIN_CODE_1;
      3'd2: g = `GAIN_CODE_2;
      3'd3: g = `GAIN_CODE_3;
      3'd4: g = `GAIN_CODE_4;
      3'd5: g = `GAIN_CODE_5;
      3'd6: g = `GAIN_CODE_6;
      default: g = `GAIN_CODE_7;
    endcase
    case (c.opcode)
      `OP_CFG_GAIN: if (c.byte2[1:0] != 2'b11)
        e = '{1'b1, 1'b1, '{3'(c.byte2[1:0]) + 3'd1, {`POT_PREFIX, g}}, `RESP_ACK};
      `OP_TRIG_LVL: if (c.byte3 >= 8'd46 && c.byte3 <= 8'd201)
        e = '{1'b1, 1'b1, '{3'b000, {`POT_PREFIX, c.byte3}}, `RESP_ACK};
      `OP_EEP_WRT: e = '{1'b1, 1'b1, '{3'b100, {2'b01, c.byte2[5:0], c.byte3}}, `RESP_ACK};
      `OP_EEP_RD:  e = '{1'b1, 1'b1, '{3'b100, {2'b00, c.byte2[5:0], 8'h00}}, eep};
      `OP_TRIG_POS, `OP_SET_DEC, `OP_TRIG_CFG: e.rsp = 1'b0;   // Silent register writes
      `OP_TRIG_RD: e.resp = cfg;
      default: e.resp = `RESP_NAK;
    endcase
    return e;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // SPI peripheral answers after a random wait
  always begin
    @(negedge clk);
    if (rst_n && wrt_SPI) begin
      spi_wait = next_rand() % 8;
      repeat (spi_wait) @(posedge clk);
      @(posedge clk);
      SPI_done <= 1'b1;
      EEP_data <= eep_byte;
      @(posedge clk);
      SPI_done <= 1'b0;
    end
  end

  // UART transmitter finishes after a random wait
  always begin
    @(negedge clk);
    if (rst_n && send_resp) begin
      host_wait = next_rand() % 12;
      repeat (host_wait) @(posedge clk);
      @(posedge clk);
      resp_sent <= 1'b1;
      @(posedge clk);
      resp_sent <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic send_cmd(input logic [7:0] op, input logic [7:0] b2, input logic [7:0] b3);
    dso_pkg::host_cmd_t c;
    logic [7:0] eb;
    c  = '{op, b2, b3};
    eb = next_rand() >> 8;
    @(posedge clk);
    eep_byte <= eb;
    exp_q    <= expected_reply(c, cfg_model, eb);
    cmd      <= c;
    cmd_rdy  <= 1'b1;
    cmd_sent <= cmd_sent + 1;
    do @(negedge clk); while (!clr_cmd_rdy);
    @(posedge clk);
    cmd_rdy <= 1'b0;
    if (op == `OP_TRIG_CFG)
      cfg_model = {2'b00, b2[5:0]};
  endtask

  task automatic end_test();
    @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
    test_num  <= test_num + 1;
  endtask

  ////////////////////
  // Capture with optional early edge
  ////////////////////
  task automatic run_capture(input logic early);
    int pulses;
    int quiet;
    int target;
    pulses = 0;
    quiet  = 0;
    target = `RAM_DEPTH - POS + (early ? 20 : 0);
    @(posedge clk);
    cap_mode  <= 1'b1;
    edge_mark <= 1'b0;
    send_cmd(`OP_TRIG_POS, 8'h00, 8'(POS));
    send_cmd(`OP_SET_DEC, 8'h00, 8'h02);
    send_cmd(`OP_TRIG_CFG, 8'h15, 8'h00);  // Rising, normal, trig2
    while (pulses < target) begin
      @(negedge clk);
      if (we) begin
        pulses++;
        if (early && (pulses == 50 || pulses == 52)) begin
          @(posedge clk);
          trig2 <= (pulses == 50);         // Pulse before armed
        end
      end
    end
    @(posedge clk);
    trig2     <= 1'b1;
    edge_mark <= 1'b1;
    while (quiet < 64) begin
      @(negedge clk);
      quiet = we ? 0 : quiet + 1;
    end
    @(posedge clk);
    trig2 <= 1'b0;
    cfg_model[5] = 1'b1;                   // Capture done sets d
    send_cmd(`OP_TRIG_RD, 8'h00, 8'h00);
    @(posedge clk);
    cap_mode <= 1'b0;
    end_test();
  endtask

  initial begin
    lcg_state = 32'h174b6cf3;
    {trig1, trig2, cmd_rdy, resp_sent, SPI_done} = '0;
    {EEP_data, eep_byte, cfg_model} = '0;
    {test_done, cap_mode, edge_mark, finish_req} = '0;
    cmd = '0;
    exp_q = '0;
    cmd_sent = 0;
    cycles = 0;
    test_num = 1;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (20) @(posedge clk);
    end_test();
    for (int g = 0; g < 8; g++)
      for (int ch = 0; ch < 3; ch++)
        send_cmd(`OP_CFG_GAIN, {3'b000, 3'(g), 2'(ch)}, 8'h00);
    send_cmd(`OP_TRIG_LVL, 8'h00, 8'd46);
    send_cmd(`OP_TRIG_LVL, 8'h00, 8'd201);
    for (int i = 0; i < 3; i++) begin
      send_cmd(`OP_EEP_WRT, 8'(next_rand()), 8'(next_rand() >> 4));
      send_cmd(`OP_EEP_RD, 8'(next_rand()), 8'h00);
    end
    end_test();
    send_cmd(8'h00, 8'h00, 8'h00);
    send_cmd(8'h0A, 8'h00, 8'h00);
    send_cmd(8'hFF, 8'h00, 8'h00);
    send_cmd(`OP_DUMP_CH, 8'h01, 8'h00);
    send_cmd(`OP_CFG_GAIN, 8'h07, 8'h00);  // Channel code 11
    send_cmd(`OP_TRIG_LVL, 8'h00, 8'd45);
    send_cmd(`OP_TRIG_LVL, 8'h00, 8'd202);
    end_test();
    send_cmd(`OP_TRIG_CFG, 8'hD2, 8'h00);  // Top bits dropped, type stopped
    send_cmd(`OP_TRIG_RD, 8'h00, 8'h00);
    send_cmd(`OP_TRIG_CFG, 8'h03, 8'h00);
    send_cmd(`OP_TRIG_RD, 8'h00, 8'h00);
    end_test();
    run_capture(1'b0);
    run_capture(1'b1);
    finish_req <= 1'b1;
    repeat (3) @(posedge clk);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
